// File: Bender.yml
package:
  name: lsu_mem_top

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - rtl/mem_cfg_pkg.sv
      - rtl/lsu_types_pkg.sv
      - rtl/lsu_ctrl_fsm.sv
      - rtl/restore_counter.sv
      - rtl/spec_data_mem.sv
      - rtl/commit_data_mem.sv
      - rtl/load_align.sv
      - rtl/lsu_mem_top.sv

  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_lsu_mem_top.sv

// File: lsu_mem_top.f
+incdir+tb
rtl/mem_cfg_pkg.sv
rtl/lsu_types_pkg.sv
rtl/lsu_ctrl_fsm.sv
rtl/restore_counter.sv
rtl/spec_data_mem.sv
rtl/commit_data_mem.sv
rtl/load_align.sv
rtl/lsu_mem_top.sv
tb/tb_lsu_mem_top.sv

// File: rtl/commit_data_mem.sv
`timescale 1ns/1ps

module commit_data_mem (
    input  logic                              clk,
    input  logic                              reset,
    input  lsu_types_pkg::commit_t            commit,
    input  logic [mem_cfg_pkg::WORD_IDX_W-1:0] word_idx,
    output logic [31:0]                       restore_word
);

    logic [31:0] mem [mem_cfg_pkg::MEM_WORDS];

    logic [mem_cfg_pkg::WORD_IDX_W-1:0] cmt_idx;
    lsu_types_pkg::lane_t               lane;
    logic [31:0]                        merged;

    assign cmt_idx = commit.addr[mem_cfg_pkg::WORD_IDX_W+1:2];  // Retired stores are in range
    assign lane    = lsu_types_pkg::lane_mask(commit.op, commit.addr[1:0], commit.wdata);

    always_comb begin
        merged = mem[cmt_idx];
        for (int b = 0; b < 4; b++) begin
            if (lane.be[b]) begin
                merged[8*b +: 8] = lane.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_cfg_pkg::MEM_WORDS; i++) begin
                mem[i] <= mem_cfg_pkg::init_word(i);
            end
        end else if (commit.valid) begin
            mem[cmt_idx] <= merged;
        end
    end

    // Write-first read, a commit to the word being swept is not lost
    always_ff @(posedge clk) begin
        if (commit.valid && (cmt_idx == word_idx)) begin
            restore_word <= merged;
        end else begin
            restore_word <= mem[word_idx];
        end
    end

endmodule

// File: rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  lsu_types_pkg::ls_req_t  acc,
    input  logic                    acc_fault,
    input  logic [31:0]             rd_word,
    output lsu_types_pkg::ls_resp_t resp
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_data;

    assign byte_sel = rd_word[{acc.addr[1:0], 3'b000} +: 8];
    assign half_sel = rd_word[{acc.addr[1], 4'b0000} +: 16];

    always_comb begin
        case (acc.op)
            lsu_types_pkg::OP_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
            lsu_types_pkg::OP_LH:  load_data = {{16{half_sel[15]}}, half_sel};
            lsu_types_pkg::OP_LW:  load_data = rd_word;
            lsu_types_pkg::OP_LBU: load_data = {24'h0, byte_sel};
            lsu_types_pkg::OP_LHU: load_data = {16'h0, half_sel};
            default:               load_data = acc.wdata;  // Stores echo their data
        endcase
    end

    always_comb begin
        resp.valid    = acc.valid;
        resp.fault    = acc.valid && acc_fault;
        resp.is_store = acc.op[3];
        resp.data     = acc_fault ? 32'h0 : load_data;
        resp.addr     = acc.addr;
        resp.inst_num = acc.inst_num;
        resp.phy_tag  = acc.phy_tag;
    end

endmodule

// File: rtl/lsu_ctrl_fsm.sv
`timescale 1ns/1ps

module lsu_ctrl_fsm (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic last,
    output logic busy,
    output logic accept,
    output logic start,
    output logic run
);

    typedef enum logic {
        IDLE,
        RESTORE
    } state_e;

    state_e state;
    state_e state_next;
    logic   last_q;  // Final word's write lands next cycle

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (flush) begin
                    state_next = RESTORE;
                end
            end
            RESTORE: begin
                if (last_q) begin  // Flushes here are ignored
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            last_q <= 1'b0;
        end else begin
            state  <= state_next;
            last_q <= last;
        end
    end

    assign busy   = (state == RESTORE);
    assign accept = ~busy;
    assign start  = (state == IDLE) && flush;  // Clears the counter on the flush edge
    assign run    = busy && !last_q;           // Read phase of the sweep

    // A sweep occupies exactly one cycle per word plus one
    a_sweep_len: assert property (@(posedge clk) disable iff (reset)
        start |=> (state == RESTORE) [* mem_cfg_pkg::MEM_WORDS + 1] ##1 (state == IDLE))
        else $error("restore sweep length wrong");

endmodule

// File: rtl/lsu_mem_top.sv
`timescale 1ns/1ps

module lsu_mem_top (
    input  logic                    clk,
    input  logic                    reset,
    input  lsu_types_pkg::ls_req_t  req,
    input  lsu_types_pkg::commit_t  commit,
    input  logic                    flush,
    output lsu_types_pkg::ls_resp_t resp,
    output logic                    busy
);

    logic                               accept;
    logic                               start;
    logic                               run;
    logic                               last;
    logic [mem_cfg_pkg::WORD_IDX_W-1:0] word_idx;
    logic [mem_cfg_pkg::WORD_IDX_W-1:0] restore_wr_idx;
    logic                               restore_wr_en;
    logic [31:0]                        restore_word;
    lsu_types_pkg::ls_req_t             req_gated;
    lsu_types_pkg::ls_req_t             acc;
    logic                               acc_fault;
    logic [31:0]                        rd_word;

    // Requests during the sweep are dropped here
    always_comb begin
        req_gated       = req;
        req_gated.valid = req.valid && accept;
    end

    lsu_ctrl_fsm u_lsu_ctrl_fsm (
        .clk    (clk),
        .reset  (reset),
        .flush  (flush),
        .last   (last),
        .busy   (busy),
        .accept (accept),
        .start  (start),
        .run    (run)
    );

    restore_counter u_restore_counter (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .run            (run),
        .word_idx       (word_idx),
        .last           (last),
        .restore_wr_idx (restore_wr_idx),
        .restore_wr_en  (restore_wr_en)
    );

    spec_data_mem u_spec_data_mem (
        .clk                   (clk),
        .reset                 (reset),
        .req                   (req_gated),
        .commit                (commit),
        .commit_during_restore (busy),
        .restore_wr_en         (restore_wr_en),
        .restore_wr_idx        (restore_wr_idx),
        .restore_word          (restore_word),
        .acc                   (acc),
        .acc_fault             (acc_fault),
        .rd_word               (rd_word)
    );

    commit_data_mem u_commit_data_mem (
        .clk          (clk),
        .reset        (reset),
        .commit       (commit),
        .word_idx     (word_idx),
        .restore_word (restore_word)
    );

    load_align u_load_align (
        .acc       (acc),
        .acc_fault (acc_fault),
        .rd_word   (rd_word),
        .resp      (resp)
    );

endmodule

// File: rtl/lsu_types_pkg.sv
package lsu_types_pkg;

    localparam int INST_NUM_W = 32;  // ROB instruction number
    localparam int PHY_TAG_W  = 8;   // Physical destination tag

    // Store bit on top of funct3
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } mem_op_e;

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [31:0]           addr;      // Byte address
        logic [31:0]           wdata;     // Store data, low lanes
        logic [INST_NUM_W-1:0] inst_num;
        logic [PHY_TAG_W-1:0]  phy_tag;
    } ls_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  fault;
        logic                  is_store;
        logic [31:0]           data;      // Load result or store data
        logic [31:0]           addr;
        logic [INST_NUM_W-1:0] inst_num;
        logic [PHY_TAG_W-1:0]  phy_tag;
    } ls_resp_t;

    // Store retired by the reorder buffer
    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } commit_t;

    typedef struct packed {
        logic [3:0]  be;    // Byte enables
        logic [31:0] data;  // Store data moved to its lanes
    } lane_t;

    // Byte enables and lane-aligned data of a store
    function automatic lane_t lane_mask(input mem_op_e op, input logic [1:0] offset,
                                        input logic [31:0] wdata);
        lane_t lane;
        lane.be   = 4'b0000;
        lane.data = 32'h0;
        case (op)
            OP_SB: begin
                lane.be   = 4'b0001 << offset;
                lane.data = {24'h0, wdata[7:0]} << {offset, 3'b000};
            end
            OP_SH: begin
                lane.be   = offset[1] ? 4'b1100 : 4'b0011;
                lane.data = {16'h0, wdata[15:0]} << {offset[1], 4'b0000};
            end
            OP_SW: begin
                lane.be   = 4'b1111;
                lane.data = wdata;
            end
            default: ;  // Loads write nothing
        endcase
        return lane;
    endfunction

endpackage

// File: rtl/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Data memory geometry
    localparam int MEM_WORDS       = 256;   // 32-bit words per array
    localparam int WORD_IDX_W      = 8;     // Bits of a word index
    localparam int BYTE_ADDR_LIMIT = 1024;  // First byte address that faults

    // Reset contents, word i holds i + INIT_OFFSET
    localparam int INIT_OFFSET = 3;

    // Reset value of one word, shared by both arrays and the model
    function automatic logic [31:0] init_word(input int idx);
        return 32'(idx + INIT_OFFSET);
    endfunction

endpackage

// File: rtl/restore_counter.sv
`timescale 1ns/1ps

module restore_counter (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic                              run,
    output logic [mem_cfg_pkg::WORD_IDX_W-1:0] word_idx,
    output logic                              last,
    output logic [mem_cfg_pkg::WORD_IDX_W-1:0] restore_wr_idx,
    output logic                              restore_wr_en
);

    always_ff @(posedge clk) begin
        if (reset || start) begin
            word_idx <= '0;
        end else if (run) begin
            word_idx <= word_idx + 1'b1;  // Wraps to zero after the last word
        end
    end

    assign last = run &&
                  (word_idx == mem_cfg_pkg::WORD_IDX_W'(mem_cfg_pkg::MEM_WORDS - 1));

    // Delay by the committed array's read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            restore_wr_en <= 1'b0;
        end else begin
            restore_wr_en <= run;
        end
    end

    always_ff @(posedge clk) begin
        restore_wr_idx <= word_idx;
    end

    // Controller must drop run right after the final index
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        last |=> !run)
        else $error("restore sweep ran past the last word");

endmodule

// File: rtl/spec_data_mem.sv
`timescale 1ns/1ps

module spec_data_mem (
    input  logic                              clk,
    input  logic                              reset,
    input  lsu_types_pkg::ls_req_t            req,
    input  lsu_types_pkg::commit_t            commit,
    input  logic                              commit_during_restore,
    input  logic                              restore_wr_en,
    input  logic [mem_cfg_pkg::WORD_IDX_W-1:0] restore_wr_idx,
    input  logic [31:0]                       restore_word,
    output lsu_types_pkg::ls_req_t            acc,
    output logic                              acc_fault,
    output logic [31:0]                       rd_word
);

    logic [31:0] mem [mem_cfg_pkg::MEM_WORDS];

    logic [mem_cfg_pkg::WORD_IDX_W-1:0] req_idx;
    logic [mem_cfg_pkg::WORD_IDX_W-1:0] cmt_idx;
    logic                               misaligned;
    logic                               req_fault;
    logic                               req_wr;
    logic                               cmt_wr;
    lsu_types_pkg::lane_t               req_lane;
    lsu_types_pkg::lane_t               cmt_lane;

    assign req_idx = req.addr[mem_cfg_pkg::WORD_IDX_W+1:2];
    assign cmt_idx = commit.addr[mem_cfg_pkg::WORD_IDX_W+1:2];

    always_comb begin
        case (req.op)
            lsu_types_pkg::OP_LH,
            lsu_types_pkg::OP_LHU,
            lsu_types_pkg::OP_SH: misaligned = req.addr[0];
            lsu_types_pkg::OP_LW,
            lsu_types_pkg::OP_SW: misaligned = |req.addr[1:0];
            default:              misaligned = 1'b0;  // Byte accesses
        endcase
    end

    assign req_fault = (req.addr >= 32'(mem_cfg_pkg::BYTE_ADDR_LIMIT)) || misaligned;
    assign req_wr    = req.valid && req.op[3] && !req_fault;  // Faulting stores never write
    assign cmt_wr    = commit.valid && commit_during_restore;  // Keeps copied words current
    assign req_lane  = lsu_types_pkg::lane_mask(req.op, req.addr[1:0], req.wdata);
    assign cmt_lane  = lsu_types_pkg::lane_mask(commit.op, commit.addr[1:0], commit.wdata);

    // Later writes win, so a commit overrides a restore of the same word
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_cfg_pkg::MEM_WORDS; i++) begin
                mem[i] <= mem_cfg_pkg::init_word(i);
            end
        end else begin
            if (restore_wr_en) begin
                mem[restore_wr_idx] <= restore_word;
            end
            for (int b = 0; b < 4; b++) begin
                if (cmt_wr && cmt_lane.be[b]) begin
                    mem[cmt_idx][8*b +: 8] <= cmt_lane.data[8*b +: 8];
                end
                if (req_wr && req_lane.be[b]) begin
                    mem[req_idx][8*b +: 8] <= req_lane.data[8*b +: 8];
                end
            end
        end
    end

    // Old word, read on the same edge as a store merge
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rd_word <= mem[req_idx];
        end
    end

    always_ff @(posedge clk) begin
        acc       <= req;
        acc_fault <= req_fault;
        if (reset) begin
            acc.valid <= 1'b0;
        end
    end

    // Request gating at the top must keep execution writes out of the sweep
    a_no_wr_overlap: assert property (@(posedge clk) disable iff (reset)
        !(req_wr && restore_wr_en))
        else $error("request write during restore write");

endmodule

// File: tb/tb_lsu_checks.svh
`ifndef TB_LSU_CHECKS_SVH
`define TB_LSU_CHECKS_SVH

// One response per accepted request, in the following cycle
a_resp_valid: assert property (@(posedge clk) disable iff (reset)
    resp.valid == exp_resp.valid)
    else report_mismatch($sformatf("resp.valid %0b, expected %0b",
                                   $sampled(resp.valid), $sampled(exp_resp.valid)));

a_resp_fault: assert property (@(posedge clk) disable iff (reset)
    exp_resp.valid |-> (resp.fault == exp_resp.fault))
    else report_mismatch($sformatf("fault %0b, expected %0b at addr %h",
                                   $sampled(resp.fault), $sampled(exp_resp.fault),
                                   $sampled(exp_resp.addr)));

// Load value with extension, store echo, or zero on a fault
a_resp_data: assert property (@(posedge clk) disable iff (reset)
    exp_resp.valid |-> (resp.data == exp_resp.data))
    else report_mismatch($sformatf("data %h, expected %h at addr %h",
                                   $sampled(resp.data), $sampled(exp_resp.data),
                                   $sampled(exp_resp.addr)));

a_resp_kind: assert property (@(posedge clk) disable iff (reset)
    exp_resp.valid |-> (resp.is_store == exp_resp.is_store))
    else report_mismatch($sformatf("is_store %0b, expected %0b",
                                   $sampled(resp.is_store), $sampled(exp_resp.is_store)));

a_resp_tags: assert property (@(posedge clk) disable iff (reset)
    exp_resp.valid |-> (resp.addr == exp_resp.addr && resp.inst_num == exp_resp.inst_num
                        && resp.phy_tag == exp_resp.phy_tag))
    else report_mismatch($sformatf("inst %0d tag %h, expected inst %0d tag %h",
                                   $sampled(resp.inst_num), $sampled(resp.phy_tag),
                                   $sampled(exp_resp.inst_num), $sampled(exp_resp.phy_tag)));

// Sweep lasts one cycle per word plus one
a_busy: assert property (@(posedge clk) disable iff (reset)
    busy == model_busy)
    else report_mismatch($sformatf("busy %0b, expected %0b",
                                   $sampled(busy), $sampled(model_busy)));

a_dropped: assert property (@(posedge clk) disable iff (reset)
    dropped |-> !resp.valid)
    else report_mismatch("response to a request strobed while busy");

`endif

// File: tb/tb_lsu_mem_top.sv
`timescale 1ns/1ps

module tb_lsu_mem_top;

    localparam int RAND_OPS    = 40;  // Store plus five loads each
    localparam int CYCLE_LIMIT = 3 * (mem_cfg_pkg::MEM_WORDS + 1) + 2 * mem_cfg_pkg::MEM_WORDS
                                 + 10 * RAND_OPS + 800;

    logic                    clk;
    logic                    reset;
    logic                    flush;
    logic                    busy;
    lsu_types_pkg::ls_req_t  req;
    lsu_types_pkg::commit_t  commit;
    lsu_types_pkg::ls_resp_t resp;

    logic [31:0]             spec_model [mem_cfg_pkg::MEM_WORDS];
    logic [31:0]             commit_model [mem_cfg_pkg::MEM_WORDS];
    lsu_types_pkg::ls_resp_t exp_resp;  // Expected response, one cycle ahead
    logic [8:0]              busy_cnt;
    logic                    model_busy;
    logic                    dropped;   // Request strobed during the sweep

    lsu_types_pkg::commit_t  pend_q [$];  // Stores waiting to retire
    logic [31:0]             rng = 32'hb084f1ca;
    logic [31:0]             inst_ctr = 32'h0;
    int                      errors = 0;
    int                      checked = 0;
    int                      tests_done = 0;
    int                      test_err_start = 0;
    int                      cycles = 0;

    lsu_mem_top u_lsu_mem_top (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .commit (commit),
        .flush  (flush),
        .resp   (resp),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic access_faults(input lsu_types_pkg::mem_op_e op,
                                           input logic [31:0] addr);
        logic bad;
        bad = (addr >= 32'(mem_cfg_pkg::BYTE_ADDR_LIMIT));
        case (op)
            lsu_types_pkg::OP_LH, lsu_types_pkg::OP_LHU, lsu_types_pkg::OP_SH: bad |= addr[0];
            lsu_types_pkg::OP_LW, lsu_types_pkg::OP_SW: bad |= (addr[1:0] != 2'b00);
            default: ;
        endcase
        return bad;
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] old,
                                                input lsu_types_pkg::mem_op_e op,
                                                input logic [1:0] off, input logic [31:0] wdata);
        logic [31:0] res;
        res = old;
        case (op)
            lsu_types_pkg::OP_SB: res[8*off +: 8] = wdata[7:0];
            lsu_types_pkg::OP_SH: res[16*off[1] +: 16] = wdata[15:0];
            lsu_types_pkg::OP_SW: res = wdata;
            default: ;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] load_extract(input logic [31:0] word,
                                                 input lsu_types_pkg::mem_op_e op,
                                                 input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (op)
            lsu_types_pkg::OP_LB:  return {{24{b[7]}}, b};
            lsu_types_pkg::OP_LH:  return {{16{h[15]}}, h};
            lsu_types_pkg::OP_LBU: return {24'h0, b};
            lsu_types_pkg::OP_LHU: return {16'h0, h};
            default:               return word;
        endcase
    endfunction

    assign model_busy = (busy_cnt != 9'd0);

    // Shadow model, reads pre-edge inputs
    always @(posedge clk) begin
        lsu_types_pkg::ls_resp_t nxt;
        logic [7:0]              idx;
        logic [7:0]              cidx;
        if (reset) begin
            for (int i = 0; i < mem_cfg_pkg::MEM_WORDS; i++) begin
                spec_model[i]   = 32'(i + mem_cfg_pkg::INIT_OFFSET);
                commit_model[i] = 32'(i + mem_cfg_pkg::INIT_OFFSET);
            end
            exp_resp <= '0;
            dropped  <= 1'b0;
            busy_cnt <= 9'd0;
        end else begin
            nxt = '0;
            idx = req.addr[9:2];
            if (req.valid && !model_busy) begin
                nxt.valid    = 1'b1;
                nxt.fault    = access_faults(req.op, req.addr);
                nxt.is_store = req.op[3];
                nxt.addr     = req.addr;
                nxt.inst_num = req.inst_num;
                nxt.phy_tag  = req.phy_tag;
                if (nxt.fault) begin
                    nxt.data = 32'h0;
                end else if (req.op[3]) begin
                    nxt.data        = req.wdata;
                    spec_model[idx] = store_merge(spec_model[idx], req.op, req.addr[1:0],
                                                  req.wdata);
                end else begin
                    nxt.data = load_extract(spec_model[idx], req.op, req.addr[1:0]);
                end
                checked++;
            end
            exp_resp <= nxt;
            dropped  <= req.valid && model_busy;
            if (commit.valid) begin
                cidx = commit.addr[9:2];
                commit_model[cidx] = store_merge(commit_model[cidx], commit.op,
                                                 commit.addr[1:0], commit.wdata);
                if (model_busy) begin
                    spec_model[cidx] = store_merge(spec_model[cidx], commit.op,
                                                   commit.addr[1:0], commit.wdata);
                end
            end
            if (flush && !model_busy) begin
                busy_cnt <= 9'(mem_cfg_pkg::MEM_WORDS + 1);
            end else if (model_busy) begin
                if (busy_cnt == 9'd1) begin  // Sweep done, speculative equals committed
                    for (int i = 0; i < mem_cfg_pkg::MEM_WORDS; i++) begin
                        spec_model[i] = commit_model[i];
                    end
                end
                busy_cnt <= busy_cnt - 9'd1;
            end
        end
    end

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic issue(input lsu_types_pkg::mem_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata);
        req.valid    <= 1'b1;
        req.op       <= op;
        req.addr     <= addr;
        req.wdata    <= wdata;
        req.inst_num <= inst_ctr;
        req.phy_tag  <= inst_ctr[7:0] + 8'd17;
        inst_ctr++;
        @(posedge clk);
        req.valid <= 1'b0;
    endtask

    task automatic retire(input lsu_types_pkg::mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata);
        commit <= '{valid: 1'b1, op: op, addr: addr, wdata: wdata};
        @(posedge clk);
        commit.valid <= 1'b0;
    endtask

    task automatic start_flush();
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic wait_restore();
        do @(posedge clk); while (busy);  // Timeout counter bounds this
    endtask

    task automatic read_all_words();
        for (int w = 0; w < mem_cfg_pkg::MEM_WORDS; w++) begin
            issue(lsu_types_pkg::OP_LW, 32'(w) << 2, 32'h0);
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);  // Let the last response be checked
        tests_done++;
        $display("[%0t] test %0d %s: %s", $time, tests_done, name,
                 (errors == test_err_start) ? "ok" : "errors");
        test_err_start = errors;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0]             a;
        logic [31:0]             d;
        lsu_types_pkg::mem_op_e  op;
        lsu_types_pkg::commit_t  c;
        reset  = 1'b1;
        flush  = 1'b0;
        req    = '0;
        commit = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int k = 0; k < 16; k++) begin
            d = rand_word();
            issue(lsu_types_pkg::OP_LW, {22'h0, d[7:0], 2'b00}, 32'h0);
        end
        issue(lsu_types_pkg::OP_LW, 32'h0, 32'h0);
        issue(lsu_types_pkg::OP_LW, 32'h3fc, 32'h0);
        end_test("reset contents");

        for (int k = 0; k < RAND_OPS; k++) begin
            case (rand_word() % 3)
                0:       op = lsu_types_pkg::OP_SB;
                1:       op = lsu_types_pkg::OP_SH;
                default: op = lsu_types_pkg::OP_SW;
            endcase
            a = rand_word() & 32'h3ff;
            if (op == lsu_types_pkg::OP_SH) a[0] = 1'b0;
            if (op == lsu_types_pkg::OP_SW) a[1:0] = 2'b00;
            d = rand_word();
            issue(op, a, d);
            if (k % 3 == 0) pend_q.push_back('{valid: 1'b1, op: op, addr: a, wdata: d});
            issue(lsu_types_pkg::OP_LB, a, 32'h0);
            issue(lsu_types_pkg::OP_LBU, a, 32'h0);
            issue(lsu_types_pkg::OP_LH, {a[31:1], 1'b0}, 32'h0);
            issue(lsu_types_pkg::OP_LHU, {a[31:1], 1'b0}, 32'h0);
            issue(lsu_types_pkg::OP_LW, {a[31:2], 2'b00}, 32'h0);
        end
        end_test("random stores and loads");

        for (int k = 0; k < 4; k++) begin
            a = rand_word() & 32'h3fc;
            d = rand_word();
            issue(lsu_types_pkg::OP_SW, a | 32'h1, d);       // Misaligned word
            issue(lsu_types_pkg::OP_SH, a | 32'h3, d);       // Misaligned half
            issue(lsu_types_pkg::OP_LH, a | 32'h1, 32'h0);
            issue(lsu_types_pkg::OP_LW, a | 32'h2, 32'h0);
            issue(lsu_types_pkg::OP_SW, a | 32'h400, d);     // Aliases word a if unchecked
            issue(lsu_types_pkg::OP_LB, a | 32'hffff0000, 32'h0);
            issue(lsu_types_pkg::OP_LW, a, 32'h0);
        end
        end_test("faults leave memory unchanged");

        for (int k = 0; k < 12; k++) begin
            a = rand_word() & 32'h3fc;
            d = rand_word();
            op = (k % 2 == 0) ? lsu_types_pkg::OP_SW : lsu_types_pkg::OP_SB;
            issue(op, a, d);
            if (k % 4 == 0) pend_q.push_back('{valid: 1'b1, op: op, addr: a, wdata: d});
        end
        while (pend_q.size() != 0) begin
            c = pend_q.pop_front();
            retire(c.op, c.addr, c.wdata);
        end
        start_flush();
        wait_restore();
        read_all_words();
        end_test("flush restores committed copy");

        start_flush();
        repeat (20) @(posedge clk);
        retire(lsu_types_pkg::OP_SW, 32'd8, rand_word());     // Word 2, already copied
        retire(lsu_types_pkg::OP_SH, 32'h2a, rand_word());
        retire(lsu_types_pkg::OP_SB, 32'd1001, rand_word());  // Word 250, not yet copied
        wait_restore();
        read_all_words();
        end_test("commits during restore");

        start_flush();
        issue(lsu_types_pkg::OP_LW, 32'h0, 32'h0);
        issue(lsu_types_pkg::OP_SW, 32'h4, rand_word());
        issue(lsu_types_pkg::OP_LB, 32'h3, 32'h0);
        wait_restore();
        issue(lsu_types_pkg::OP_LW, 32'h4, 32'h0);
        end_test("requests dropped while busy");

        $display("Summary: %0d tests, %0d responses checked, %0d failures",
                 tests_done, checked, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    `include "tb_lsu_checks.svh"

endmodule
